// ==== build.f ====
+incdir+test
rtl/icache_geom_pkg.sv
rtl/icache_bus_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
test/icache_mem_model.sv
test/icache_props.sv
test/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache testbench, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module icache_tb -o icache_sim \
  && ./obj_dir/icache_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q '^>>> PASS$' sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== test/icache_mem_ref.svh ====
// memory image as a function of the word address
// every address bit feeds the result, so aliased lines differ
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  logic [31:0] a;
  a = {addr[31:2], 2'b00};
  return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
endfunction

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

  localparam logic [3:0] UNC_REGION = 4'hA;
  localparam int MAX_STALL = 3;
  localparam int MAX_GAP = 3;
  localparam int RAND_N = 200;
  localparam int N_FETCH = 2 + 17 + 4 + 5 + RAND_N;
  // capture, lookup, 16 beats behind full stalls, final lookup, idle gap
  localparam int MISS_CYC = 4 + 16 * (MAX_STALL + 1) + MAX_GAP;
  localparam int WATCHDOG_NS = (40 + N_FETCH * MISS_CYC) * 10;

  logic clk = 1'b0;
  logic rst;
  icache_geom_pkg::fetch_addr_t fetch_addr;
  logic fetch_valid;
  icache_bus_pkg::fetch_resp_t fetch_resp;
  icache_bus_pkg::mem_req_t mem_req;
  icache_bus_pkg::mem_resp_t mem_resp;

  // expected words and requests in fetch order
  logic [31:0] exp_data_q[$];
  icache_bus_pkg::mem_req_t exp_req_q[$];
  // shadow of the direct-mapped tag store
  logic [18:0] shadow_tag[128];
  bit shadow_valid[128];

  int req_pred, miss_pred, unc_pred, check_err;
  int req_seen, resp_seen, cmp_err;
  int tests_passed, tests_failed, test_num, req_base, pred_base, err_base;
  string test_name;
  logic req_valid_d = 1'b0;

  `include "icache_mem_ref.svh"

  always #5 clk = ~clk;

  icache_top UUT (
    .clk                 (clk),
    .rst                 (rst),
    .preif_raddr_i       (fetch_addr),
    .preif_raddr_valid_i (fetch_valid),
    .if_resp_o           (fetch_resp),
    .mem_req_o           (mem_req),
    .mem_resp_i          (mem_resp)
  );

  icache_mem_model #(.MAX_STALL(MAX_STALL)) u_mem (
    .clk        (clk),
    .rst        (rst),
    .mem_req_i  (mem_req),
    .mem_resp_o (mem_resp)
  );

  // expected word and request for one fetch
  // 64 byte lines with the index in bits 12:6 and the tag above
  task automatic predict(input logic [31:0] addr);
    icache_bus_pkg::mem_req_t req;
    logic [6:0] idx;
    idx = addr[12:6];
    req.valid = 1'b1;
    exp_data_q.push_back(mem_word(addr));
    if (addr[31:28] == UNC_REGION) begin
      req.addr = addr;
      req.len = 8'd0;
      exp_req_q.push_back(req);
      req_pred++;
      unc_pred++;
    end else if (!shadow_valid[idx] || shadow_tag[idx] != addr[31:13]) begin
      req.addr = {addr[31:6], 6'b0};
      req.len = 8'd15;
      exp_req_q.push_back(req);
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx] = addr[31:13];
      req_pred++;
      miss_pred++;
    end
  endtask

  // returns in the response cycle with valid still high
  task automatic fetch(input logic [31:0] addr, output int lat);
    fetch_addr.flat = addr;
    fetch_valid = 1'b1;
    predict(addr);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!fetch_resp.valid);
  endtask

  // zero cycles keeps the next fetch back to back
  task automatic pause(input int cycles);
    if (cycles > 0) begin
      fetch_valid = 1'b0;
      fetch_addr.flat = $urandom();
      repeat (cycles) @(negedge clk);
    end
  endtask

  task automatic start_test(input int num, input string name);
    test_num = num;
    test_name = name;
    req_base = req_seen;
    pred_base = req_pred;
    err_base = check_err + cmp_err;
  endtask

  task automatic finish_test();
    int errs;
    pause(2);
    assert (exp_data_q.size() == 0) else begin
      $display("test %0d: %0d fetches never got a response", test_num, exp_data_q.size());
      check_err++;
    end
    assert (exp_req_q.size() == 0) else begin
      $display("test %0d: %0d predicted memory requests never appeared",
               test_num, exp_req_q.size());
      check_err++;
    end
    assert (req_seen - req_base == req_pred - pred_base) else begin
      $display("FAIL @%0t: test %0d saw %0d memory requests, expected %0d",
               $time, test_num, req_seen - req_base, req_pred - pred_base);
      check_err++;
    end
    errs = check_err + cmp_err - err_base;
    if (errs == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %0d %s: %0d requests, %0d errors",
             test_num, test_name, req_seen - req_base, errs);
  endtask

  // compare against the expected queues where outputs are stable
  always @(negedge clk) begin
    icache_bus_pkg::mem_req_t er;
    logic [31:0] ed;
    if (!rst) begin
      // a new request starts on a rising valid
      if (mem_req.valid && !req_valid_d) begin
        req_seen++;
        assert (exp_req_q.size() > 0) else begin
          $display("unexpected memory request at %h at %0t", mem_req.addr, $time);
          cmp_err++;
        end
        if (exp_req_q.size() > 0) begin
          er = exp_req_q.pop_front();
          assert (mem_req.addr == er.addr && mem_req.len == er.len) else begin
            $display("FAIL @%0t: request %h len %0d, expected %h len %0d",
                     $time, mem_req.addr, mem_req.len, er.addr, er.len);
            cmp_err++;
          end
        end
      end
      if (fetch_resp.valid) begin
        resp_seen++;
        assert (exp_data_q.size() > 0) else begin
          $display("response at %0t with no fetch outstanding", $time);
          cmp_err++;
        end
        if (exp_data_q.size() > 0) begin
          ed = exp_data_q.pop_front();
          assert (fetch_resp.data == ed) else begin
            $display("FAIL @%0t: fetch data %h, expected %h", $time, fetch_resp.data, ed);
            cmp_err++;
          end
        end
      end
    end
    req_valid_d = mem_req.valid;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run still busy after %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    int lat;
    logic [31:0] addr;
    void'($urandom(32'h1634_5d59));
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr.flat = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    start_test(1, "cold miss then hit");
    fetch(32'h0000_1040, lat);
    pause(1);
    fetch(32'h0000_1048, lat);
    finish_test();

    // fill the line then read every word of it back to back
    start_test(2, "streaming hits");
    fetch(32'h0000_3000, lat);
    for (int w = 0; w < 16; w++) begin
      fetch(32'h0000_3000 + 32'(w * 4), lat);
      assert (lat == 1) else begin
        $display("FAIL @%0t: hit on word %0d took %0d cycles", $time, w, lat);
        check_err++;
      end
    end
    finish_test();

    // same index with tags 1 and 2
    start_test(3, "conflict eviction");
    for (int k = 0; k < 4; k++) begin
      fetch(k[0] ? 32'h0000_4084 : 32'h0000_2080, lat);
      pause(1);
    end
    finish_test();

    start_test(4, "uncached bypass");
    fetch(32'h0000_1234, lat);
    pause(1);
    repeat (3) begin
      fetch(32'hA000_1234, lat);
      pause(2);
    end
    // cached line at the same index still there
    fetch(32'h0000_1238, lat);
    finish_test();

    // 32 KB window over the 8 KB cache with one in eight uncached
    start_test(5, "random stream");
    for (int i = 0; i < RAND_N; i++) begin
      addr = ($urandom_range(7, 0) == 0) ? 32'hA000_0000 : 32'h0000_0000;
      addr = addr | ($urandom() & 32'h0000_7FFC);
      fetch(addr, lat);
      pause($urandom_range(MAX_GAP, 0));
    end
    finish_test();

    assert (UUT.u_props.fail_cnt == 0) else begin
      $display("bound property checks failed %0d times", UUT.u_props.fail_cnt);
      check_err++;
    end
    $display("tests %0d, passed %0d, failed %0d, responses %0d, requests %0d (%0d miss, %0d unc)",
             tests_passed + tests_failed, tests_passed, tests_failed, resp_seen, req_seen,
             miss_pred, unc_pred);
    if (tests_failed == 0 && check_err == 0 && cmp_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== test/icache_props.sv ====
`timescale 1ns/1ps

module icache_props (
  input logic                        clk,
  input logic                        rst,
  input icache_bus_pkg::mem_req_t    mem_req_i,
  input icache_bus_pkg::fetch_resp_t if_resp_i
);

  // failures seen so far
  int unsigned fail_cnt = 0;

  // address and length hold for the whole burst
  req_stable: assert property (@(posedge clk) disable iff (rst)
    (mem_req_i.valid && $past(mem_req_i.valid))
      |-> ($stable(mem_req_i.addr) && $stable(mem_req_i.len)))
    else begin
      $error("memory request address or length changed while valid");
      fail_cnt++;
    end

  // single beat bypass or full line only
  req_len: assert property (@(posedge clk) disable iff (rst)
    mem_req_i.valid |-> (mem_req_i.len == 8'd0 || mem_req_i.len == 8'd15))
    else begin
      $error("memory request length is neither 0 nor 15");
      fail_cnt++;
    end

  // no response while memory is still busy
  resp_idle: assert property (@(posedge clk) disable iff (rst)
    mem_req_i.valid |-> !if_resp_i.valid)
    else begin
      $error("fetch response while a memory request is pending");
      fail_cnt++;
    end

  // quiet first cycle out of reset
  reset_quiet: assert property (@(posedge clk)
    $fell(rst) |=> (!mem_req_i.valid && !if_resp_i.valid))
    else begin
      $error("valid output high in the cycle after reset");
      fail_cnt++;
    end

endmodule

bind icache_top icache_props u_props (
  .clk       (clk),
  .rst       (rst),
  .mem_req_i (mem_req_o),
  .if_resp_i (if_resp_o)
);

// ==== test/icache_mem_model.sv ====
`timescale 1ns/1ps

module icache_mem_model #(
  parameter int MAX_STALL = 3
) (
  input  logic                      clk,
  input  logic                      rst,
  input  icache_bus_pkg::mem_req_t  mem_req_i,
  output icache_bus_pkg::mem_resp_t mem_resp_o
);

  `include "icache_mem_ref.svh"

  icache_bus_pkg::mem_resp_t resp_q = '0;
  // beat index inside the current burst
  logic [7:0] beat_q = '0;
  // idle cycles left before the next beat
  int stall_q = 0;

  assign mem_resp_o = resp_q;

  // ready set here always transfers on the next rising edge,
  // valid holds until the last beat is taken
  always @(negedge clk) begin
    if (rst || !mem_req_i.valid) begin
      resp_q.ready <= 1'b0;
      resp_q.data  <= '0;
      beat_q       <= '0;
      stall_q      <= $urandom_range(MAX_STALL, 0);
    end else if (stall_q != 0) begin
      // stalled, no beat this cycle
      resp_q.ready <= 1'b0;
      stall_q      <= stall_q - 1;
    end else begin
      // beat k is the word at addr + 4k
      resp_q.ready <= 1'b1;
      resp_q.data  <= mem_word(mem_req_i.addr + {22'd0, beat_q, 2'b00});
      beat_q       <= beat_q + 8'd1;
      stall_q      <= $urandom_range(MAX_STALL, 0);
    end
  end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top #(
  // top nibble of the bypass region
  parameter logic [3:0] UNCACHED_REGION = 4'hA
) (
  input  logic                         clk,
  input  logic                         rst,
  input  icache_geom_pkg::fetch_addr_t preif_raddr_i,
  input  logic                         preif_raddr_valid_i,
  output icache_bus_pkg::fetch_resp_t  if_resp_o,
  output icache_bus_pkg::mem_req_t     mem_req_o,
  input  icache_bus_pkg::mem_resp_t    mem_resp_i
);

  // captured address shared by both arrays
  icache_geom_pkg::fetch_addr_t lookup_addr;

  logic                                  hit;
  logic [icache_bus_pkg::DATA_W-1:0]     line_word;
  logic                                  fill_done;
  logic                                  beat_we;
  logic [icache_geom_pkg::WORD_SEL_W-1:0] beat_sel;
  logic [icache_bus_pkg::DATA_W-1:0]     beat_data;

  icache_ctrl #(
    .UNCACHED_REGION(UNCACHED_REGION)
  ) u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .preif_raddr_i       (preif_raddr_i),
    .preif_raddr_valid_i (preif_raddr_valid_i),
    .hit_i               (hit),
    .line_word_i         (line_word),
    .lookup_addr_o       (lookup_addr),
    .fill_done_o         (fill_done),
    .beat_we_o           (beat_we),
    .beat_sel_o          (beat_sel),
    .beat_data_o         (beat_data),
    .if_resp_o           (if_resp_o),
    .mem_req_o           (mem_req_o),
    .mem_resp_i          (mem_resp_i)
  );

  // valid bits and tags
  icache_tag_array u_tag (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .fill_done_i   (fill_done),
    .hit_o         (hit)
  );

  // line words
  icache_data_array u_data (
    .clk           (clk),
    .lookup_addr_i (lookup_addr),
    .beat_we_i     (beat_we),
    .beat_sel_i    (beat_sel),
    .beat_data_i   (beat_data),
    .line_word_o   (line_word)
  );

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl #(
  parameter logic [3:0] UNCACHED_REGION = 4'hA
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  icache_geom_pkg::fetch_addr_t           preif_raddr_i,
  input  logic                                  preif_raddr_valid_i,
  input  logic                                  hit_i,
  input  logic [icache_bus_pkg::DATA_W-1:0]      line_word_i,
  output icache_geom_pkg::fetch_addr_t           lookup_addr_o,
  output logic                                  fill_done_o,
  output logic                                  beat_we_o,
  output logic [icache_geom_pkg::WORD_SEL_W-1:0] beat_sel_o,
  output logic [icache_bus_pkg::DATA_W-1:0]      beat_data_o,
  output icache_bus_pkg::fetch_resp_t            if_resp_o,
  output icache_bus_pkg::mem_req_t               mem_req_o,
  input  icache_bus_pkg::mem_resp_t              mem_resp_i
);

  localparam int AW = icache_geom_pkg::ADDR_W;
  localparam int OW = icache_geom_pkg::OFFSET_W;
  localparam int WSW = icache_geom_pkg::WORD_SEL_W;
  localparam int DW = icache_bus_pkg::DATA_W;
  localparam int LW = icache_bus_pkg::LEN_W;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNC,
    ST_UNC_RESP
  } state_t;

  state_t state_q;

  // capture stage
  icache_geom_pkg::fetch_addr_t addr_q;

  // outstanding memory request
  logic          req_valid_q;
  logic [AW-1:0] req_addr_q;
  logic [LW-1:0] req_len_q;

  // beats taken so far in the current burst
  logic [LW-1:0] beat_cnt_q;

  // word held for an uncached response
  logic [DW-1:0] unc_data_q;

  logic          is_uncached;
  logic          lookup_hit;
  logic          resp_fire;
  logic          take_addr;
  logic          beat_fire;
  logic          last_beat;
  logic [AW-1:0] line_addr;

  // region check on the top nibble takes priority over the tag result
  assign is_uncached = (addr_q.flat[AW-1 -: 4] == UNCACHED_REGION);
  assign lookup_hit = (state_q == ST_LOOKUP) && !is_uncached && hit_i;

  // resolve stage sends a response from lookup or after the bypass beat
  assign resp_fire = lookup_hit || (state_q == ST_UNC_RESP);

  // ready for a new address in idle or in any response cycle
  assign take_addr = preif_raddr_valid_i && ((state_q == ST_IDLE) || resp_fire);

  assign beat_fire = req_valid_q && mem_resp_i.ready;
  assign last_beat = (beat_cnt_q == req_len_q);

  // refill starts at the line base
  assign line_addr = {addr_q.flat[AW-1:OW], {OW{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_RESET;
      req_valid_q <= 1'b0;
      beat_cnt_q  <= '0;
    end else begin
      case (state_q)
        // one quiet cycle out of reset
        ST_RESET: begin
          state_q <= ST_IDLE;
        end
        ST_IDLE: begin
          if (preif_raddr_valid_i) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (is_uncached) begin
            // single beat bypass that is never allocated
            req_valid_q <= 1'b1;
            state_q     <= ST_UNC;
          end else if (hit_i) begin
            // stay put when the next fetch is already there
            if (!preif_raddr_valid_i) begin
              state_q <= ST_IDLE;
            end
          end else begin
            req_valid_q <= 1'b1;
            beat_cnt_q  <= '0;
            state_q     <= ST_REFILL;
          end
        end
        ST_REFILL: begin
          if (beat_fire) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            // tag is written on this edge and lookup then hits
            if (last_beat) begin
              req_valid_q <= 1'b0;
              state_q     <= ST_LOOKUP;
            end
          end
        end
        ST_UNC: begin
          if (beat_fire) begin
            req_valid_q <= 1'b0;
            state_q     <= ST_UNC_RESP;
          end
        end
        ST_UNC_RESP: begin
          state_q <= preif_raddr_valid_i ? ST_LOOKUP : ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // address capture and request payload
  always_ff @(posedge clk) begin
    if (take_addr) begin
      addr_q <= preif_raddr_i;
    end
    // request fields latch as the request is raised
    if ((state_q == ST_LOOKUP) && !lookup_hit) begin
      if (is_uncached) begin
        req_addr_q <= addr_q.flat;
        req_len_q  <= '0;
      end else begin
        req_addr_q <= line_addr;
        req_len_q  <= LW'(icache_geom_pkg::BURST_LEN_LINE);
      end
    end
    if ((state_q == ST_UNC) && beat_fire) begin
      unc_data_q <= mem_resp_i.data;
    end
  end

  // lookup stage reads both arrays from the captured address
  assign lookup_addr_o = addr_q;

  // refill write port
  assign beat_we_o   = (state_q == ST_REFILL) && beat_fire;
  assign beat_sel_o  = beat_cnt_q[WSW-1:0];
  assign beat_data_o = mem_resp_i.data;
  assign fill_done_o = beat_we_o && last_beat;

  // response mux picks the bypass word or the array word
  assign if_resp_o.valid = resp_fire;
  assign if_resp_o.data  = (state_q == ST_UNC_RESP) ? unc_data_q : line_word_i;

  assign mem_req_o.valid = req_valid_q;
  assign mem_req_o.addr  = req_addr_q;
  assign mem_req_o.len   = req_len_q;

endmodule

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/1ps

module icache_data_array (
  input  logic                                           clk,
  input  icache_geom_pkg::fetch_addr_t                    lookup_addr_i,
  input  logic                                           beat_we_i,
  input  logic [icache_geom_pkg::WORD_SEL_W-1:0]          beat_sel_i,
  input  logic [icache_bus_pkg::DATA_W-1:0]               beat_data_i,
  output logic [icache_bus_pkg::DATA_W-1:0]               line_word_o
);

  localparam int NL = icache_geom_pkg::NUM_LINES;
  localparam int WPL = icache_geom_pkg::WORDS_PER_LINE;
  localparam int DW = icache_bus_pkg::DATA_W;
  localparam int IW = icache_geom_pkg::INDEX_W;
  localparam int WSW = icache_geom_pkg::WORD_SEL_W;

  // line by word storage
  logic [DW-1:0] mem_q [NL][WPL];

  logic [IW-1:0]  idx;
  logic [WSW-1:0] rd_sel;

  assign idx = lookup_addr_i.fields.index;
  assign rd_sel = lookup_addr_i.fields.word_sel;

  // refill beats go into the captured line
  // beat_sel walks the words in burst order
  always_ff @(posedge clk) begin
    if (beat_we_i) begin
      mem_q[idx][beat_sel_i] <= beat_data_i;
    end
  end

  // async read of the fetched word
  assign line_word_o = mem_q[idx][rd_sel];

endmodule

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/1ps

module icache_tag_array (
  input  logic                        clk,
  input  logic                        rst,
  input  icache_geom_pkg::fetch_addr_t lookup_addr_i,
  input  logic                        fill_done_i,
  output logic                        hit_o
);

  localparam int NL = icache_geom_pkg::NUM_LINES;
  localparam int TW = icache_geom_pkg::TAG_W;
  localparam int IW = icache_geom_pkg::INDEX_W;

  // one valid bit per line
  logic [NL-1:0] valid_q;
  // stored tags, only meaningful where valid is set
  logic [TW-1:0] tag_q [NL];

  logic [IW-1:0] idx;
  logic [TW-1:0] tag;

  // lookup fields from the captured address
  assign idx = lookup_addr_i.fields.index;
  assign tag = lookup_addr_i.fields.tag;

  // valid bits come up cleared
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_done_i) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tag lands on the last refill beat
  always_ff @(posedge clk) begin
    if (fill_done_i) begin
      tag_q[idx] <= tag;
    end
  end

  // combinational compare against the current entry
  assign hit_o = valid_q[idx] && (tag_q[idx] == tag);

endmodule

// ==== rtl/icache_bus_pkg.sv ====
package icache_bus_pkg;

  // one beat on either side is a 32-bit word
  parameter int DATA_W = 32;

  // burst length field, beats minus one
  parameter int LEN_W = 8;

  // request to memory
  // addr and len hold steady while valid is high
  typedef struct packed {
    logic                              valid;
    logic [icache_geom_pkg::ADDR_W-1:0] addr;
    logic [LEN_W-1:0]                  len;
  } mem_req_t;

  // one beat back from memory, ready strobes the beat
  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] data;
  } mem_resp_t;

  // word back to the core, valid is a single cycle pulse
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } fetch_resp_t;

endpackage

// ==== rtl/icache_geom_pkg.sv ====
package icache_geom_pkg;

  // fetch address width, byte addressed
  parameter int ADDR_W = 32;

  // 64 byte line
  parameter int OFFSET_W = 6;

  // 128 lines, direct mapped
  parameter int INDEX_W = 7;

  // whatever is left above index and offset
  parameter int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // word within a line
  parameter int WORD_SEL_W = 4;

  parameter int NUM_LINES = 1 << INDEX_W;
  parameter int WORDS_PER_LINE = 1 << WORD_SEL_W;

  // len field for a full line refill, 15 means 16 beats
  parameter int BURST_LEN_LINE = WORDS_PER_LINE - 1;

  // split view of a fetch address
  // byte offset stays 2 bits, the core only sends word aligned fetches
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [WORD_SEL_W-1:0] word_sel;
    logic [1:0]            byte_off;
  } fetch_addr_fields_t;

  // same word seen flat or split
  // flat side feeds the memory request and the region check,
  // field side feeds the tag and data lookups
  typedef union packed {
    logic [ADDR_W-1:0]  flat;
    fetch_addr_fields_t fields;
  } fetch_addr_t;

endpackage
